//--- Makefile
# Verilator build and run of the game controller testbench
# any variable can be overridden, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_dino_game_ctrl
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
SIM_ARGS  ?=

.PHONY: sim clean

# the simulation binary exits non-zero on $fatal, so make fails with the test
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

//--- src/collision_check.sv
`timescale 1ns/1ps

module collision_check
  import game_types_pkg::*, game_geom_pkg::*;
(
  input  logic        frame_Clk,
  input  logic        Reset,
  input  game_state_e state,
  input  dino_box_t   dino_box,
  input  ptero_t      ptero,
  input  cactus_t     cactus,
  output logic        dead
);

  logic signed [11:0] pt_x [4];
  logic signed [11:0] pt_y [4];
  logic signed [11:0] top;
  logic signed [11:0] right;
  logic signed [11:0] quarter;
  logic               hit_ptero;
  logic               hit_cactus;
  logic               dead_q;

  // half-open box test, left/top inclusive and right/bottom exclusive
  function automatic logic in_box(
    input logic signed [11:0] px,
    input logic signed [11:0] py,
    input logic signed [11:0] left,
    input logic signed [11:0] upper,
    input logic signed [11:0] w,
    input logic signed [11:0] h
  );
    logic in_x;
    logic in_y;
    in_x = (px >= left) && (px < left + w);
    in_y = (py >= upper) && (py < upper + h);
    return in_x && in_y;
  endfunction

  assign top     = dino_box.cy - $signed({2'b00, dino_box.h[9:1]});
  assign quarter = $signed({3'b000, dino_box.h[9:2]});
  assign right   = dino_box.cx + 12'(DINO_W / 2);

  // two points on the snout edge, two on the body center line
  always_comb
  begin
    pt_x[0] = right;
    pt_y[0] = top;
    pt_x[1] = right;
    pt_y[1] = top + quarter;
    pt_x[2] = 12'(dino_box.cx);
    pt_y[2] = top;
    pt_x[3] = 12'(dino_box.cx);
    pt_y[3] = dino_box.cy + quarter;
  end

  always_comb
  begin
    hit_ptero  = 1'b0;
    hit_cactus = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      hit_ptero  |= in_box(pt_x[i], pt_y[i],
                           $signed({2'b00, ptero.pos.x}), $signed({2'b00, ptero.pos.y}),
                           12'(PTERO_W), 12'(PTERO_H));
      hit_cactus |= in_box(pt_x[i], pt_y[i],
                           $signed({2'b00, cactus.pos.x}), $signed({2'b00, cactus.pos.y}),
                           $signed({2'b00, cactus.w}), $signed({2'b00, cactus.h}));
    end
    // hidden obstacles are off screen
    hit_ptero  = hit_ptero && !ptero.hidden;
    hit_cactus = hit_cactus && !cactus.hidden;
  end

  always_ff @(posedge frame_Clk or posedge Reset)
  begin
    if (Reset)
    begin
      dead_q <= 1'b0;
    end
    else
    begin
      dead_q <= (state == ST_GAME) && (hit_ptero || hit_cactus);
    end
  end

  assign dead = dead_q;

endmodule

//--- src/dino_game_ctrl.sv
`timescale 1ns/1ps

module dino_game_ctrl
  import game_types_pkg::*, game_geom_pkg::*;
(
  input  logic         frame_Clk,
  input  logic         Reset,
  input  key_code_e    keycode,
  input  ptero_t       ptero,
  input  cactus_t      cactus,
  output game_state_e  game_state,
  output dino_action_e action,
  output screen_pos_t  dino_pos,
  output logic         dead
);

  game_state_e state;
  dino_box_t   dino_box;
  logic        dead_w;

  game_fsm u_fsm (
    .frame_Clk (frame_Clk),
    .Reset     (Reset),
    .keycode   (keycode),
    .dead      (dead_w),
    .state     (state)
  );

  dino_motion u_motion (
    .frame_Clk (frame_Clk),
    .Reset     (Reset),
    .state     (state),
    .keycode   (keycode),
    .dead      (dead_w),
    .dino_box  (dino_box),
    .action    (action)
  );

  collision_check u_collision (
    .frame_Clk (frame_Clk),
    .Reset     (Reset),
    .state     (state),
    .dino_box  (dino_box),
    .ptero     (ptero),
    .cactus    (cactus),
    .dead      (dead_w)
  );

  // renderer wants the top-left corner of the sprite
  assign dino_pos.x = 10'(dino_box.cx - 11'(DINO_W / 2));
  assign dino_pos.y = 10'(dino_box.cy - $signed({1'b0, dino_box.h[9:1]}));

  assign game_state = state;
  assign dead       = dead_w;

endmodule

//--- src/dino_motion.sv
`timescale 1ns/1ps

module dino_motion
  import game_types_pkg::*, game_geom_pkg::*;
(
  input  logic         frame_Clk,
  input  logic         Reset,
  input  game_state_e  state,
  input  key_code_e    keycode,
  input  logic         dead,
  output dino_box_t    dino_box,
  output dino_action_e action
);

  dino_box_t               box_q;
  dino_box_t               box_d;
  dino_box_t               home_box;
  dino_action_e            act_q;
  dino_action_e            act_d;
  logic signed [VEL_W-1:0] vel_q;
  logic signed [VEL_W-1:0] vel_d;
  logic signed [VEL_W-1:0] v_eff;
  logic [CHARGE_W-1:0]     charge_q;
  logic [CHARGE_W-1:0]     charge_d;
  logic [GRAV_W-1:0]       grav_cnt;
  logic                    grav_tick;
  logic                    key_held;
  logic signed [11:0]      feet;
  logic                    grounded;

  assign home_box = '{cx: 11'(DINO_X), cy: 11'(DINO_STAND_CY), h: 10'(DINO_H)};

  // frame divider, gravity is applied on its last count
  always_ff @(posedge frame_Clk or posedge Reset)
  begin
    if (Reset)
    begin
      grav_cnt <= '0;
    end
    else if (grav_cnt == GRAV_W'(GRAV_DIV - 1))
    begin
      grav_cnt <= '0;
    end
    else
    begin
      grav_cnt <= grav_cnt + 1'b1;
    end
  end

  assign grav_tick = (grav_cnt == GRAV_W'(GRAV_DIV - 1));
  assign key_held  = (keycode == KEY_SPACE) || (keycode == KEY_UP);
  assign feet      = box_q.cy + $signed({2'b00, box_q.h[9:1]});
  assign grounded  = (feet == GROUND_LEVEL);

  always_comb
  begin
    box_d    = box_q;
    vel_d    = vel_q;
    charge_d = charge_q;
    act_d    = act_q;
    v_eff    = vel_q;
    if (state == ST_START)
    begin
      box_d    = home_box;
      vel_d    = '0;
      charge_d = '0;
      act_d    = ACT_REST;
    end
    else if (state == ST_OVER || dead)
    begin
      // frozen in place until the round restarts
      vel_d = '0;
      act_d = ACT_DEAD;
    end
    else
    begin
      if (key_held && charge_q < CHARGE_FULL)
      begin
        charge_d = charge_q + 1'b1;
      end
      // launch only from the ground, a press in mid-air is ignored
      if (grounded)
      begin
        if (keycode == KEY_NONE && charge_q != '0)
        begin
          if (charge_q <= CHARGE_SHORT_MAX)
          begin
            v_eff = VEL_W'(JUMP_SHORT_V);
          end
          else
          begin
            v_eff = VEL_W'(JUMP_LONG_V);
          end
        end
        else if (key_held && charge_q == CHARGE_FULL)
        begin
          v_eff = VEL_W'(JUMP_LONG_V);
        end
      end
      if (feet < GROUND_LEVEL)
      begin
        charge_d = '0;
      end
      if (v_eff >= 0 && feet + v_eff >= GROUND_LEVEL)
      begin
        // touchdown, snap feet to the ground line
        vel_d = '0;
        if (keycode == KEY_DOWN)
        begin
          box_d.cy = 11'(DINO_DUCK_CY);
          box_d.h  = 10'(DINO_DUCK_H);
          act_d    = ACT_DUCK;
        end
        else
        begin
          box_d.cy = 11'(DINO_STAND_CY);
          box_d.h  = 10'(DINO_H);
          act_d    = ACT_RUN;
        end
      end
      else
      begin
        box_d.cy = box_q.cy + 11'(v_eff);
        act_d    = ACT_JUMP;
        vel_d    = grav_tick ? v_eff + VEL_W'(GRAVITY) : v_eff;
      end
    end
  end

  always_ff @(posedge frame_Clk or posedge Reset)
  begin
    if (Reset)
    begin
      box_q    <= home_box;
      vel_q    <= '0;
      charge_q <= '0;
      act_q    <= ACT_REST;
    end
    else
    begin
      box_q    <= box_d;
      vel_q    <= vel_d;
      charge_q <= charge_d;
      act_q    <= act_d;
    end
  end

  assign dino_box = box_q;
  assign action   = act_q;

endmodule

//--- src/game_fsm.sv
`timescale 1ns/1ps

module game_fsm
  import game_types_pkg::*;
(
  input  logic        frame_Clk,
  input  logic        Reset,
  input  key_code_e   keycode,
  input  logic        dead,
  output game_state_e state
);

  game_state_e state_q;
  game_state_e state_d;

  always_ff @(posedge frame_Clk or posedge Reset)
  begin
    if (Reset)
    begin
      state_q <= ST_START;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // hold the current state unless a key or a death moves it
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_START:
      begin
        if (keycode == KEY_SPACE || keycode == KEY_UP)
        begin
          state_d = ST_GAME;
        end
      end
      ST_GAME:
      begin
        if (dead)
        begin
          state_d = ST_OVER;
        end
      end
      ST_OVER:
      begin
        // enter restarts the round
        if (keycode == KEY_ENTER)
        begin
          state_d = ST_START;
        end
      end
      default:
      begin
        state_d = ST_START;
      end
    endcase
  end

  assign state = state_q;

endmodule

//--- src/game_geom_pkg.sv
package game_geom_pkg;

  // feet line, middle of the ground sprite
  localparam int GROUND_LEVEL = 412;

  // dinosaur sprite, x is the fixed center column
  localparam int DINO_X      = 94;
  localparam int DINO_W      = 88;
  localparam int DINO_H      = 94;
  localparam int DINO_DUCK_H = 60;

  // center y when standing or ducking on the ground
  localparam int DINO_STAND_CY = GROUND_LEVEL - DINO_H / 2;
  localparam int DINO_DUCK_CY  = GROUND_LEVEL - DINO_DUCK_H / 2;

  localparam int PTERO_W = 92;
  localparam int PTERO_H = 80;

  // launch velocities in pixels per frame, negative is up
  localparam int JUMP_SHORT_V = -10;
  localparam int JUMP_LONG_V  = -11;

  // charge thresholds in frames of key hold
  localparam int CHARGE_SHORT_MAX = 15;
  localparam int CHARGE_FULL      = 30;
  localparam int CHARGE_W         = $clog2(CHARGE_FULL + 1);

  localparam int GRAVITY  = 3;
  localparam int GRAV_DIV = 4;
  localparam int GRAV_W   = $clog2(GRAV_DIV);

  // vertical velocity register width
  localparam int VEL_W = 8;

endpackage

//--- src/game_types_pkg.sv
package game_types_pkg;

  // keyboard scan codes the controller reacts to
  typedef enum logic [7:0] {
    KEY_NONE  = 8'h00,
    KEY_ENTER = 8'h28,
    KEY_SPACE = 8'h2C,
    KEY_DOWN  = 8'h51,
    KEY_UP    = 8'h52
  } key_code_e;

  typedef enum logic [1:0] {
    ST_START = 2'd0,
    ST_GAME  = 2'd1,
    ST_OVER  = 2'd2
  } game_state_e;

  // sprite selection for the renderer
  typedef enum logic [2:0] {
    ACT_REST,
    ACT_RUN,
    ACT_JUMP,
    ACT_DUCK,
    ACT_DEAD
  } dino_action_e;

  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
  } screen_pos_t;

  // pos is the top-left corner of the sprite
  typedef struct packed {
    logic        hidden;
    screen_pos_t pos;
  } ptero_t;

  typedef struct packed {
    logic        hidden;
    screen_pos_t pos;
    logic [9:0]  w;
    logic [9:0]  h;
  } cactus_t;

  // hitbox, center based, signed so the math can go off screen
  typedef struct packed {
    logic signed [10:0] cx;
    logic signed [10:0] cy;
    logic        [9:0]  h;
  } dino_box_t;

endpackage

//--- tests/tb_vectors.svh
// columns: name, keycode, pterosaur, cactus, roam, hold, state, action, dead, peak
// roam puts random far x positions on the obstacles, peak 1 or 2 records the short or long top

localparam ptero_t NO_PTERO  = '{hidden: 1'b1, pos: '{x: 10'd0, y: 10'd0}};
localparam ptero_t FAR_PTERO = '{hidden: 1'b0, pos: '{x: 10'd600, y: 10'd300}};
// covers the standing head row but stays above a ducked head
localparam ptero_t HEAD_PTERO = '{hidden: 1'b0, pos: '{x: 10'd60, y: 10'd240}};

localparam cactus_t NO_CACTUS     = '{1'b1, '{10'd0, 10'd0}, 10'd0, 10'd0};
localparam cactus_t FAR_CACTUS    = '{1'b0, '{10'd600, 10'd370}, 10'd40, 10'd42};
localparam cactus_t HIT_CACTUS    = '{1'b0, '{10'd80, 10'd370}, 10'd40, 10'd42};
localparam cactus_t SHADOW_CACTUS = '{1'b1, '{10'd80, 10'd370}, 10'd40, 10'd42};

localparam int NUM_VEC = 21;

vec_t vectors [NUM_VEC] = '{
  '{"enter idle", KEY_ENTER, NO_PTERO, NO_CACTUS, 1'b0, 3, ST_START, ACT_REST, 1'b0, 0},
  '{"start", KEY_SPACE, NO_PTERO, NO_CACTUS, 1'b0, 1, ST_GAME, ACT_REST, 1'b0, 0},
  '{"run", KEY_NONE, NO_PTERO, NO_CACTUS, 1'b0, 4, ST_GAME, ACT_RUN, 1'b0, 0},
  '{"short charge", KEY_SPACE, NO_PTERO, NO_CACTUS, 1'b0, 5, ST_GAME, ACT_RUN, 1'b0, 0},
  '{"short launch", KEY_NONE, NO_PTERO, NO_CACTUS, 1'b0, 2, ST_GAME, ACT_JUMP, 1'b0, 0},
  '{"short fall", KEY_NONE, FAR_PTERO, FAR_CACTUS, 1'b1, 50, ST_GAME, ACT_RUN, 1'b0, 1},
  '{"long charge", KEY_UP, NO_PTERO, NO_CACTUS, 1'b0, 31, ST_GAME, ACT_JUMP, 1'b0, 0},
  '{"long rise", KEY_NONE, NO_PTERO, NO_CACTUS, 1'b0, 3, ST_GAME, ACT_JUMP, 1'b0, 0},
  '{"air press", KEY_SPACE, NO_PTERO, NO_CACTUS, 1'b0, 4, ST_GAME, ACT_JUMP, 1'b0, 0},
  '{"long fall", KEY_NONE, FAR_PTERO, FAR_CACTUS, 1'b1, 50, ST_GAME, ACT_RUN, 1'b0, 2},
  '{"duck", KEY_DOWN, NO_PTERO, NO_CACTUS, 1'b0, 2, ST_GAME, ACT_DUCK, 1'b0, 0},
  '{"duck ptero", KEY_DOWN, HEAD_PTERO, NO_CACTUS, 1'b0, 3, ST_GAME, ACT_DUCK, 1'b0, 0},
  '{"stand", KEY_NONE, NO_PTERO, NO_CACTUS, 1'b0, 2, ST_GAME, ACT_RUN, 1'b0, 0},
  '{"hidden cactus", KEY_NONE, NO_PTERO, SHADOW_CACTUS, 1'b0, 4, ST_GAME, ACT_RUN, 1'b0, 0},
  '{"cactus hit", KEY_NONE, NO_PTERO, HIT_CACTUS, 1'b0, 1, ST_GAME, ACT_RUN, 1'b1, 0},
  '{"game over", KEY_NONE, NO_PTERO, HIT_CACTUS, 1'b0, 1, ST_OVER, ACT_DEAD, 1'b1, 0},
  '{"frozen", KEY_NONE, NO_PTERO, HIT_CACTUS, 1'b0, 3, ST_OVER, ACT_DEAD, 1'b0, 0},
  '{"restart", KEY_ENTER, NO_PTERO, HIT_CACTUS, 1'b0, 1, ST_START, ACT_DEAD, 1'b0, 0},
  '{"home", KEY_NONE, NO_PTERO, NO_CACTUS, 1'b0, 2, ST_START, ACT_REST, 1'b0, 0},
  '{"start again", KEY_UP, NO_PTERO, NO_CACTUS, 1'b0, 1, ST_GAME, ACT_REST, 1'b0, 0},
  '{"run again", KEY_NONE, FAR_PTERO, FAR_CACTUS, 1'b1, 4, ST_GAME, ACT_RUN, 1'b0, 0}
};

//--- tests/tb_dino_game_ctrl.sv
`timescale 1ns/1ps

module tb_dino_game_ctrl
  import game_types_pkg::*, game_geom_pkg::*;
();

  typedef struct {
    string        name;
    key_code_e    key;
    ptero_t       ptero;
    cactus_t      cactus;
    logic         roam;
    int           hold;
    game_state_e  exp_state;
    dino_action_e exp_action;
    logic         exp_dead;
    int           peak;
  } vec_t;

  logic         frame_Clk = 1'b0;
  logic         Reset;
  key_code_e    keycode;
  ptero_t       ptero;
  cactus_t      cactus;
  game_state_e  game_state;
  dino_action_e action;
  screen_pos_t  dino_pos;
  logic         dead;

  // reference model of the game, stepped on every rising edge
  game_state_e m_state;
  logic        m_dead;
  int          m_cy;
  int          m_h;
  int          m_vel;
  int          m_charge;
  int          m_grav;

  logic [31:0] lfsr = 32'h6e36;
  logic [9:0]  min_y;
  logic [9:0]  short_top;
  logic [9:0]  long_top;
  int          cycle_cnt = 0;
  int          cycle_limit;

  `include "tb_vectors.svh"

  dino_game_ctrl DUT (
    .frame_Clk  (frame_Clk),
    .Reset      (Reset),
    .keycode    (keycode),
    .ptero      (ptero),
    .cactus     (cactus),
    .game_state (game_state),
    .action     (action),
    .dino_pos   (dino_pos),
    .dead       (dead)
  );

  always #4 frame_Clk = ~frame_Clk;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic in_rect(input int px, input int py, input int l, input int t,
                                   input int w, input int h);
    return (px >= l) && (px < l + w) && (py >= t) && (py < t + h);
  endfunction

  // four probe points of the model dinosaur against one obstacle box
  function automatic logic box_hit(input int l, input int t, input int w, input int h);
    int top;
    int q;
    int rx;
    top = m_cy - m_h / 2;
    q   = m_h / 4;
    rx  = DINO_X + DINO_W / 2;
    return in_rect(rx, top, l, t, w, h) || in_rect(rx, top + q, l, t, w, h) ||
           in_rect(DINO_X, top, l, t, w, h) || in_rect(DINO_X, m_cy + q, l, t, w, h);
  endfunction

  function automatic screen_pos_t model_pos();
    screen_pos_t p;
    p.x = 10'(DINO_X - DINO_W / 2);
    p.y = 10'(m_cy - m_h / 2);
    return p;
  endfunction

  task automatic random_bits(input int n, output logic [9:0] val);
    val = '0;
    for (int b = 0; b < n; b++)
    begin
      val  = {val[8:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_state(input string name, input game_state_e exp, input game_state_e got);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %s: game_state expected %s, actual %s",
                         name, exp.name(), got.name()));
  endtask

  task automatic check_action(input string name, input dino_action_e exp,
                              input dino_action_e got);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %s: action expected %s, actual %s",
                         name, exp.name(), got.name()));
  endtask

  task automatic check_pos(input string name, input screen_pos_t exp, input screen_pos_t got);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %s: dino_pos expected (%0d, %0d), actual (%0d, %0d)",
                         name, exp.x, exp.y, got.x, got.y));
  endtask

  task automatic check_dead(input string name, input logic exp, input logic got);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %s: dead expected %b, actual %b", name, exp, got));
  endtask

  task automatic model_reset();
    m_state  = ST_START;
    m_dead   = 1'b0;
    m_cy     = GROUND_LEVEL - DINO_H / 2;
    m_h      = DINO_H;
    m_vel    = 0;
    m_charge = 0;
  endtask

  // one frame of the game rules, using the inputs seen at this edge
  task automatic step_model();
    game_state_e nxt_state;
    logic        nxt_dead;
    logic        held;
    logic        tick;
    int          feet;
    int          v;
    int          nxt_charge;
    held   = (keycode == KEY_SPACE) || (keycode == KEY_UP);
    tick   = (m_grav == GRAV_DIV - 1);
    m_grav = tick ? 0 : m_grav + 1;
    nxt_state = m_state;
    if (m_state == ST_START && held)
      nxt_state = ST_GAME;
    else if (m_state == ST_GAME && m_dead)
      nxt_state = ST_OVER;
    else if (m_state == ST_OVER && keycode == KEY_ENTER)
      nxt_state = ST_START;
    nxt_dead = (m_state == ST_GAME) &&
               ((!ptero.hidden && box_hit(int'(ptero.pos.x), int'(ptero.pos.y),
                                          PTERO_W, PTERO_H)) ||
                (!cactus.hidden && box_hit(int'(cactus.pos.x), int'(cactus.pos.y),
                                           int'(cactus.w), int'(cactus.h))));
    if (m_state == ST_START)
      model_reset();
    else if (m_state == ST_OVER || m_dead)
      m_vel = 0;
    else
    begin
      feet       = m_cy + m_h / 2;
      v          = m_vel;
      nxt_charge = m_charge;
      if (held && m_charge < CHARGE_FULL)
        nxt_charge = m_charge + 1;
      if (feet == GROUND_LEVEL)
      begin
        if (keycode == KEY_NONE && m_charge > 0)
          v = (m_charge <= CHARGE_SHORT_MAX) ? JUMP_SHORT_V : JUMP_LONG_V;
        else if (held && m_charge == CHARGE_FULL)
          v = JUMP_LONG_V;
      end
      if (feet < GROUND_LEVEL)
        nxt_charge = 0;
      m_charge = nxt_charge;
      if (v >= 0 && feet + v >= GROUND_LEVEL)
      begin
        m_vel = 0;
        m_h   = (keycode == KEY_DOWN) ? DINO_DUCK_H : DINO_H;
        m_cy  = GROUND_LEVEL - m_h / 2;
      end
      else
      begin
        m_cy  = m_cy + v;
        m_vel = tick ? v + GRAVITY : v;
      end
    end
    m_state = nxt_state;
    m_dead  = nxt_dead;
  endtask

  task automatic apply_vector(input int i);
    ptero_t     p;
    cactus_t    c;
    logic [9:0] rx;
    p = vectors[i].ptero;
    c = vectors[i].cactus;
    if (vectors[i].roam)
    begin
      random_bits(8, rx);
      p.pos.x = 10'd400 + rx;
      random_bits(8, rx);
      c.pos.x = 10'd400 + rx;
    end
    keycode <= vectors[i].key;
    ptero   <= p;
    cactus  <= c;
  endtask

  always @(posedge frame_Clk)
  begin
    if (!Reset)
    begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > cycle_limit)
        fail_run($sformatf("timeout, the run went past %0d cycles", cycle_limit));
    end
  end

  initial
  begin
    cycle_limit = 50;
    for (int i = 0; i < NUM_VEC; i++)
      cycle_limit += vectors[i].hold;
    Reset   = 1'b1;
    keycode = KEY_NONE;
    ptero   = NO_PTERO;
    cactus  = NO_CACTUS;
    min_y   = '1;
    repeat (3) @(posedge frame_Clk);
    Reset <= 1'b0;
    model_reset();
    // gravity divider is cleared only by reset and keeps counting in START
    m_grav = 0;
    @(negedge frame_Clk);
    check_state("reset", ST_START, game_state);
    check_action("reset", ACT_REST, action);
    check_dead("reset", 1'b0, dead);
    check_pos("reset", model_pos(), dino_pos);
    @(posedge frame_Clk);
    step_model();
    apply_vector(0);
    for (int i = 0; i < NUM_VEC; i++)
    begin
      for (int c = 0; c < vectors[i].hold; c++)
      begin
        @(posedge frame_Clk);
        step_model();
        // next entry goes out on the last edge so each is sampled hold times
        if (c == vectors[i].hold - 1 && i + 1 < NUM_VEC)
          apply_vector(i + 1);
        @(negedge frame_Clk);
        check_pos(vectors[i].name, model_pos(), dino_pos);
        if (dino_pos.y < min_y)
          min_y = dino_pos.y;
      end
      check_state(vectors[i].name, vectors[i].exp_state, game_state);
      check_action(vectors[i].name, vectors[i].exp_action, action);
      check_dead(vectors[i].name, vectors[i].exp_dead, dead);
      if (vectors[i].peak == 1)
        short_top = min_y;
      if (vectors[i].peak == 2)
        long_top = min_y;
      if (vectors[i].peak != 0)
        min_y = '1;
    end
    // smaller y is higher on screen
    if (short_top > long_top)
    begin
      $display("Simulation PASSED");
      $finish;
    end
    else
    begin
      fail_run($sformatf("short jump top y %0d is not below long jump top y %0d",
                         short_top, long_top));
    end
  end

endmodule

//--- verilog.f
src/game_types_pkg.sv
src/game_geom_pkg.sv
src/game_fsm.sv
src/dino_motion.sv
src/collision_check.sv
src/dino_game_ctrl.sv
+incdir+tests
tests/tb_dino_game_ctrl.sv
